/* cart_defines.svh */
`ifndef CART_DEFINES_SVH
`define CART_DEFINES_SVH

// ------------------------------
// MSX I/O ports of the SSG
// ------------------------------
// Register number latch
`define SSG_PORT_ADDR	8'hA0
// Register data write
`define SSG_PORT_WRITE	8'hA1
// Register data read
`define SSG_PORT_READ	8'hA2

// Register slots behind the latch
`define SSG_REG_COUNT	16

// ------------------------------
// Timing in clk cycles
// ------------------------------
// Clean high samples before reset release
`define RESET_STRETCH	6
// Bus wait after reset release
`define WAIT_CYCLES		16
// Clocks per tone counter tick
`define TONE_DIV		16
// PWM counter width, 64 cycle period
`define PWM_BITS		6

`endif

/* cart_pkg.sv */
package cart_pkg;

	// ------------------------------
	// Bus decode
	// ------------------------------

	// Decoded SSG bus operation
	typedef enum logic [1:0] {
		OP_NONE			= 2'd0,
		OP_ADDR_LATCH	= 2'd1,
		OP_DATA_WRITE	= 2'd2,
		OP_DATA_READ	= 2'd3
	} ssg_op_t;

	// Decoder state, one request per strobe
	typedef enum logic {
		ST_IDLE	= 1'b0,
		ST_BUSY	= 1'b1
	} bus_state_t;

	// One-cycle request to the tone core
	typedef struct packed {
		ssg_op_t		op;
		logic	[7:0]	data;
	} ssg_req_t;

	// ------------------------------
	// Sound path
	// ------------------------------

	// Linear channel levels, volume or silence
	typedef struct packed {
		logic	[3:0]	level_a;
		logic	[3:0]	level_b;
		logic	[3:0]	level_c;
	} ssg_levels_t;

endpackage

/* cart_timing.sv */
`timescale 1ns/1ns
`include "cart_defines.svh"

module cart_timing (
	input	logic	clk,
	input	logic	n_treset,
	output	logic	w_n_reset = 1'b0,
	output	logic	twait = 1'b1,
	output	logic	tone_tick = 1'b0
);

	// Power-up state
	logic	[`RESET_STRETCH-1:0]		ff_reset_sr = '0;
	logic	[$clog2(`WAIT_CYCLES)-1:0]	ff_wait_cnt = '0;
	logic	[$clog2(`TONE_DIV)-1:0]		ff_div_cnt = '0;
	logic								reset_ok;

	// ------------------------------
	// Reset stretcher
	// ------------------------------
	// Release only after a full run of high samples
	assign reset_ok = &ff_reset_sr;

	always_ff @(posedge clk) begin
		ff_reset_sr	<= {ff_reset_sr[`RESET_STRETCH-2:0], n_treset};
		w_n_reset	<= reset_ok;
	end

	// ------------------------------
	// Power-up wait
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_wait_cnt	<= '0;
			twait		<= 1'b1;
		end else if (ff_wait_cnt == `WAIT_CYCLES - 1) begin
			// Held here for good
			twait		<= 1'b0;
		end else begin
			ff_wait_cnt	<= ff_wait_cnt + 1'b1;
		end
	end

	// ------------------------------
	// Tone tick divider
	// ------------------------------
	// Follows the stretcher directly so ticks stop with w_n_reset
	always_ff @(posedge clk) begin
		if (!reset_ok) begin
			ff_div_cnt	<= '0;
			tone_tick	<= 1'b0;
		end else begin
			ff_div_cnt	<= (ff_div_cnt == `TONE_DIV - 1) ? '0 : ff_div_cnt + 1'b1;
			tone_tick	<= (ff_div_cnt == `TONE_DIV - 1);
		end
	end

	// No tone activity inside reset
	assert property (@(posedge clk) !w_n_reset |-> !tone_tick);

endmodule

/* ssg_bus_decode.sv */
`timescale 1ns/1ns
`include "cart_defines.svh"

module ssg_bus_decode import cart_pkg::*; (
	input	logic			clk,
	input	logic			w_n_reset,
	input	logic			n_tiorq,
	input	logic			n_tmerq,
	input	logic			n_twr,
	input	logic			n_trd,
	input	logic	[15:0]	ta,
	input	logic	[7:0]	wdata,
	output	ssg_req_t		req,
	output	logic			rd_active
);

	bus_state_t	ff_state;
	ssg_op_t	io_op;

	// ------------------------------
	// Port match
	// ------------------------------
	// MSX I/O space decodes the low address byte only
	always_comb begin
		io_op = OP_NONE;
		if (!n_tiorq && n_tmerq) begin
			if (!n_twr && ta[7:0] == `SSG_PORT_ADDR) begin
				io_op = OP_ADDR_LATCH;
			end else if (!n_twr && ta[7:0] == `SSG_PORT_WRITE) begin
				io_op = OP_DATA_WRITE;
			end else if (!n_trd && ta[7:0] == `SSG_PORT_READ) begin
				io_op = OP_DATA_READ;
			end
		end
	end

	// ------------------------------
	// Strobe FSM
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_state	<= ST_IDLE;
			req			<= '0;
			rd_active	<= 1'b0;
		end else begin
			// Request lasts a single cycle
			req.op <= OP_NONE;
			case (ff_state)
				ST_IDLE: begin
					if (io_op != OP_NONE) begin
						ff_state	<= ST_BUSY;
						req.op		<= io_op;
						req.data	<= wdata;
						rd_active	<= (io_op == OP_DATA_READ);
					end
				end
				ST_BUSY: begin
					// Drive the bus until the CPU lets go of RD
					if (n_trd) begin
						rd_active <= 1'b0;
					end
					// Wait for both strobes released
					if (n_twr && n_trd) begin
						ff_state <= ST_IDLE;
					end
				end
				default: ff_state <= ST_IDLE;
			endcase
		end
	end

	// Back-to-back requests would mean a strobe was counted twice
	assert property (@(posedge clk) disable iff (!w_n_reset)
		(req.op != OP_NONE) |=> (req.op == OP_NONE));

endmodule

/* ssg_tone_core.sv */
`timescale 1ns/1ns
`include "cart_defines.svh"

module ssg_tone_core import cart_pkg::*; (
	input	logic			clk,
	input	logic			w_n_reset,
	input	logic			tone_tick,
	input	ssg_req_t		req,
	output	logic	[7:0]	rdata,
	output	ssg_levels_t	levels
);

	logic	[7:0]						ff_addr;
	logic	[`SSG_REG_COUNT-1:0][7:0]	ff_regs;
	logic	[2:0][11:0]					ff_tone_cnt;
	logic	[2:0]						ff_square;
	logic								addr_valid;
	logic	[3:0]						reg_sel;
	logic	[2:0][11:0]					period;
	logic	[2:0]						tone_on;

	// Implemented bits per register slot
	function automatic logic [7:0] reg_mask(input logic [3:0] idx);
		case (idx)
			4'd0, 4'd2, 4'd4, 4'd7:	reg_mask = 8'hFF;
			4'd1, 4'd3, 4'd5:		reg_mask = 8'h0F;
			4'd6:					reg_mask = 8'h1F;
			4'd8, 4'd9, 4'd10:		reg_mask = 8'h0F;
			// Slots 11 to 15 hold nothing
			default:				reg_mask = 8'h00;
		endcase
	endfunction

	// ------------------------------
	// Register file
	// ------------------------------
	assign addr_valid	= (ff_addr < `SSG_REG_COUNT);
	assign reg_sel		= ff_addr[3:0];

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_addr	<= '0;
			ff_regs	<= '0;
		end else begin
			// Full byte kept so out-of-range numbers stay visible
			if (req.op == OP_ADDR_LATCH) begin
				ff_addr <= req.data;
			end
			if (req.op == OP_DATA_WRITE && addr_valid) begin
				ff_regs[reg_sel] <= req.data & reg_mask(reg_sel);
			end
		end
	end

	// Read-back follows the latch
	assign rdata = addr_valid ? ff_regs[reg_sel] : 8'hFF;

	// ------------------------------
	// Tone generators
	// ------------------------------
	always_comb begin
		for (int i = 0; i < 3; i++) begin
			// Coarse nibble over fine byte
			period[i] = {ff_regs[2*i+1][3:0], ff_regs[2*i]};
			if (period[i] == 12'd0) begin
				period[i] = 12'd1;
			end
			// Mixer bit set means tone off, so the channel holds its volume
			tone_on[i] = ff_regs[7][i] | ff_square[i];
		end
	end

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_tone_cnt	<= '0;
			ff_square	<= '0;
		end else if (tone_tick) begin
			for (int i = 0; i < 3; i++) begin
				// Compare with >= so a shortened period wraps at once
				if (ff_tone_cnt[i] >= period[i] - 12'd1) begin
					ff_tone_cnt[i]	<= '0;
					ff_square[i]	<= ~ff_square[i];
				end else begin
					ff_tone_cnt[i]	<= ff_tone_cnt[i] + 12'd1;
				end
			end
		end
	end

	// Linear volume gate
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			levels <= '0;
		end else begin
			levels.level_a	<= tone_on[0] ? ff_regs[8][3:0] : 4'd0;
			levels.level_b	<= tone_on[1] ? ff_regs[9][3:0] : 4'd0;
			levels.level_c	<= tone_on[2] ? ff_regs[10][3:0] : 4'd0;
		end
	end

	// Out-of-range latch leaves every register untouched
	assert property (@(posedge clk) disable iff (!w_n_reset)
		(req.op == OP_DATA_WRITE && !addr_valid) |=> $stable(ff_regs));

endmodule

/* sound_mixer_pwm.sv */
`timescale 1ns/1ns
`include "cart_defines.svh"

module sound_mixer_pwm import cart_pkg::*; (
	input	logic			clk,
	input	logic			w_n_reset,
	input	ssg_levels_t	levels,
	output	logic			tsnd
);

	logic	[`PWM_BITS-1:0]	ff_sum;
	logic	[`PWM_BITS-1:0]	ff_pwm_cnt;
	logic	[`PWM_BITS-1:0]	level_sum;

	// ------------------------------
	// Mixer
	// ------------------------------
	// Three 4-bit levels, 45 at most
	assign level_sum = `PWM_BITS'(levels.level_a)
		+ `PWM_BITS'(levels.level_b)
		+ `PWM_BITS'(levels.level_c);

	// ------------------------------
	// PWM
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_sum		<= '0;
			ff_pwm_cnt	<= '0;
			tsnd		<= 1'b0;
		end else begin
			ff_sum		<= level_sum;
			// Free-running, wraps every 64 clocks
			ff_pwm_cnt	<= ff_pwm_cnt + 1'b1;
			// High for ff_sum clocks out of each period
			tsnd		<= (ff_pwm_cnt < ff_sum);
		end
	end

	// Full scale of three channels stays under one PWM period
	assert property (@(posedge clk) disable iff (!w_n_reset)
		ff_sum <= `PWM_BITS'(45));

endmodule

/* tangcart_msx.sv */
`timescale 1ns/1ns

module tangcart_msx import cart_pkg::*; (
	input	logic			n_treset,
	input	logic			clk,
	input	logic			n_tiorq,
	input	logic			n_tmerq,
	input	logic			n_twr,
	input	logic			n_trd,
	input	logic	[15:0]	ta,
	inout	wire	[7:0]	td,
	output	logic			tdir,
	output	logic			twait,
	output	logic			tsnd
);

	logic			w_n_reset;
	logic			tone_tick;
	ssg_req_t		req;
	logic	[7:0]	rdata;
	ssg_levels_t	levels;

	// ------------------------------
	// Reset, wait and tick
	// ------------------------------
	cart_timing u_timing (
		.clk		(clk),
		.n_treset	(n_treset),
		.w_n_reset	(w_n_reset),
		.twait		(twait),
		.tone_tick	(tone_tick)
	);

	// ------------------------------
	// SSG
	// ------------------------------
	// Read level doubles as the bus buffer direction
	ssg_bus_decode u_bus_decode (
		.clk		(clk),
		.w_n_reset	(w_n_reset),
		.n_tiorq	(n_tiorq),
		.n_tmerq	(n_tmerq),
		.n_twr		(n_twr),
		.n_trd		(n_trd),
		.ta			(ta),
		.wdata		(td),
		.req		(req),
		.rd_active	(tdir)
	);

	ssg_tone_core u_tone_core (
		.clk		(clk),
		.w_n_reset	(w_n_reset),
		.tone_tick	(tone_tick),
		.req		(req),
		.rdata		(rdata),
		.levels		(levels)
	);

	// Sound out
	sound_mixer_pwm u_mixer_pwm (
		.clk		(clk),
		.w_n_reset	(w_n_reset),
		.levels		(levels),
		.tsnd		(tsnd)
	);

	// Data bus driven only during SSG reads
	assign td = tdir ? rdata : 8'hzz;

endmodule

/* tb_tangcart_msx.sv */
`timescale 1ns/1ns
`include "cart_defines.svh"

module tb_tangcart_msx;

	// Kind of bus cycle for one table row
	typedef enum logic [1:0] {
		ROW_IO_WRITE	= 2'd0,
		ROW_MEM_WRITE	= 2'd1,
		ROW_IO_READ		= 2'd2
	} row_kind_t;

	// Port plus write data or expected read data
	typedef struct packed {
		row_kind_t		kind;
		logic	[7:0]	port;
		logic	[7:0]	data;
	} row_t;

	// Bounds for the wait loops
	localparam int RELEASE_LIMIT	= `RESET_STRETCH + `WAIT_CYCLES + 4;
	localparam int STROBE_LIMIT		= 8;
	localparam int TONE_PERIOD		= 4;
	localparam int TONE_WINDOW		= 8 * TONE_PERIOD * `TONE_DIV * 2;

	logic			clk;
	logic			n_treset;
	logic			n_tiorq;
	logic			n_tmerq;
	logic			n_twr;
	logic			n_trd;
	logic	[15:0]	ta;
	logic	[7:0]	td_drive;
	logic			td_oe;
	wire	[7:0]	td;
	logic			tdir;
	logic			twait;
	logic			tsnd;
	row_t			rows[$];
	logic	[7:0]	shadow [0:10];

	tangcart_msx tangcart_msx_inst (
		.n_treset	(n_treset),
		.clk		(clk),
		.n_tiorq	(n_tiorq),
		.n_tmerq	(n_tmerq),
		.n_twr		(n_twr),
		.n_trd		(n_trd),
		.ta			(ta),
		.td			(td),
		.tdir		(tdir),
		.twait		(twait),
		.tsnd		(tsnd)
	);

	// CPU side of the data bus
	assign td = td_oe ? td_drive : 8'hzz;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	// Stored bits per AY register slot
	function automatic logic [7:0] reg_width_mask(input int idx);
		case (idx)
			// Fine periods and mixer
			0, 2, 4, 7:			reg_width_mask = 8'hFF;
			// Coarse periods and volumes
			1, 3, 5, 8, 9, 10:	reg_width_mask = 8'h0F;
			// Noise period
			6:					reg_width_mask = 8'h1F;
			default:			reg_width_mask = 8'h00;
		endcase
	endfunction

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH at %0t ns: %s got %02h expected %02h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic add_row(input row_kind_t kind, input logic [7:0] port,
			input logic [7:0] data);
		rows.push_back({kind, port, data});
	endtask

	// I/O or memory write with the strobe held two cycles
	task automatic bus_write(input logic mem_cycle, input logic [7:0] port,
			input logic [7:0] data);
		@(negedge clk);
		ta			= {8'h00, port};
		td_drive	= data;
		td_oe		= 1'b1;
		n_tiorq		= mem_cycle;
		n_tmerq		= !mem_cycle;
		n_twr		= 1'b0;
		repeat (2) @(negedge clk);
		n_twr		= 1'b1;
		n_tiorq		= 1'b1;
		n_tmerq		= 1'b1;
		td_oe		= 1'b0;
		@(negedge clk);
	endtask

	task automatic bus_read(input logic [7:0] port, input logic [7:0] exp);
		int waited;
		@(negedge clk);
		ta		= {8'h00, port};
		n_tiorq	= 1'b0;
		n_trd	= 1'b0;
		waited	= 0;
		// Bus driver turns on after the decode latency
		do begin
			@(negedge clk);
			waited++;
		end while (!tdir && waited < STROBE_LIMIT);
		assert (tdir) else begin
			$display("tdir never rose during a read of port %02h", port);
			abort_run();
		end
		check_byte("td", td, exp);
		n_tiorq	= 1'b1;
		n_trd	= 1'b1;
		waited	= 0;
		while (tdir && waited < STROBE_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		assert (!tdir) else begin
			$display("tdir stayed high after the read strobe was released");
			abort_run();
		end
	endtask

	task automatic reg_write(input logic [7:0] idx, input logic [7:0] data);
		bus_write(1'b0, `SSG_PORT_ADDR, idx);
		bus_write(1'b0, `SSG_PORT_WRITE, data);
	endtask

	task automatic count_tsnd(input int cycles, output int highs);
		highs = 0;
		repeat (cycles) begin
			@(negedge clk);
			if (tsnd) begin
				highs++;
			end
		end
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		int				highs;
		int				waited;
		int				expected;
		logic	[7:0]	value;
		logic	[3:0]	va;
		logic	[3:0]	vb;
		logic	[3:0]	vc;

		n_treset	= 1'b0;
		n_tiorq		= 1'b1;
		n_tmerq		= 1'b1;
		n_twr		= 1'b1;
		n_trd		= 1'b1;
		ta			= '0;
		td_drive	= '0;
		td_oe		= 1'b0;
		void'($urandom(32'hcdf89cda));

		// Bus held off through reset
		repeat (8) begin
			@(negedge clk);
			check_byte("twait", {7'd0, twait}, 8'h01);
		end
		check_byte("tdir", {7'd0, tdir}, 8'h00);
		check_byte("tsnd", {7'd0, tsnd}, 8'h00);
		n_treset	= 1'b1;
		waited		= 0;
		while (twait && waited < RELEASE_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		assert (!twait) else begin
			$display("twait did not fall within %0d cycles of reset release", RELEASE_LIMIT);
			abort_run();
		end
		// Wait stays released and the bus idle
		repeat (32) begin
			@(negedge clk);
			check_byte("twait", {7'd0, twait}, 8'h00);
			check_byte("tdir", {7'd0, tdir}, 8'h00);
		end

		// Read-back of every implemented register
		for (int r = 0; r < 11; r++) begin
			value		= 8'($urandom());
			shadow[r]	= value & reg_width_mask(r);
			add_row(ROW_IO_WRITE, `SSG_PORT_ADDR, 8'(r));
			add_row(ROW_IO_WRITE, `SSG_PORT_WRITE, value);
			add_row(ROW_IO_READ, `SSG_PORT_READ, shadow[r]);
		end
		// Empty slots swallow writes
		for (int r = 11; r < 16; r++) begin
			add_row(ROW_IO_WRITE, `SSG_PORT_ADDR, 8'(r));
			add_row(ROW_IO_WRITE, `SSG_PORT_WRITE, 8'($urandom()) | 8'h01);
			add_row(ROW_IO_READ, `SSG_PORT_READ, 8'h00);
		end
		// Latch past the register file with register 8 in its low nibble
		add_row(ROW_IO_WRITE, `SSG_PORT_ADDR, (8'($urandom()) & 8'hE0) | 8'h18);
		add_row(ROW_IO_WRITE, `SSG_PORT_WRITE, ~shadow[8]);
		add_row(ROW_IO_READ, `SSG_PORT_READ, 8'hFF);
		// Memory cycle and stray port aimed at register 8
		add_row(ROW_IO_WRITE, `SSG_PORT_ADDR, 8'd8);
		add_row(ROW_MEM_WRITE, `SSG_PORT_WRITE, ~shadow[8]);
		add_row(ROW_IO_WRITE, 8'hA3, ~shadow[8]);
		add_row(ROW_IO_READ, `SSG_PORT_READ, shadow[8]);
		// Whole file again to catch any stray write
		for (int r = 0; r < 11; r++) begin
			add_row(ROW_IO_WRITE, `SSG_PORT_ADDR, 8'(r));
			add_row(ROW_IO_READ, `SSG_PORT_READ, shadow[r]);
		end

		foreach (rows[i]) begin
			case (rows[i].kind)
				ROW_IO_WRITE:	bus_write(1'b0, rows[i].port, rows[i].data);
				ROW_MEM_WRITE:	bus_write(1'b1, rows[i].port, rows[i].data);
				default:		bus_read(rows[i].port, rows[i].data);
			endcase
		end

		// ------------------------------
		// Sound path
		// ------------------------------
		// All tones off so each channel sits at its volume
		va = 4'($urandom());
		vb = 4'($urandom());
		vc = 4'($urandom());
		reg_write(8'd7, 8'h3F);
		reg_write(8'd8, {4'h0, va});
		reg_write(8'd9, {4'h0, vb});
		reg_write(8'd10, {4'h0, vc});
		repeat (8) @(negedge clk);
		count_tsnd(64, highs);
		expected = int'(va) + int'(vb) + int'(vc);
		assert (highs == expected) else begin
			$display("MISMATCH at %0t ns: tsnd high count got %0d expected %0d",
				$time, highs, expected);
			abort_run();
		end

		// Channel A square at full volume with the others silent
		reg_write(8'd9, 8'h00);
		reg_write(8'd10, 8'h00);
		reg_write(8'd0, 8'(TONE_PERIOD));
		reg_write(8'd1, 8'h00);
		reg_write(8'd8, 8'h0F);
		reg_write(8'd7, 8'h3E);
		repeat (8) @(negedge clk);
		count_tsnd(TONE_WINDOW, highs);
		// Half duty of a 15/64 level
		expected = TONE_WINDOW * 15 / 128;
		assert (highs >= expected - expected / 10 && highs <= expected + expected / 10)
		else begin
			$display("MISMATCH at %0t ns: tsnd high count got %0d expected %0d within 10%%",
				$time, highs, expected);
			abort_run();
		end
		check_byte("twait", {7'd0, twait}, 8'h00);

		$display("All checks passed");
		$finish;
	end

endmodule

/* flist.f */
+incdir+.
cart_pkg.sv
cart_timing.sv
ssg_bus_decode.sv
ssg_tone_core.sv
sound_mixer_pwm.sv
tangcart_msx.sv
tb_tangcart_msx.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SSG cartridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f flist.f \
	--top-module tb_tangcart_msx \
	-o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/sim_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

echo "Simulation finished cleanly"
exit 0
